// File: verilog/bpred_pkg.sv
package bpred_pkg;

  // virtual fetch address width
  localparam int unsigned VLEN = 32;

  // compressed instructions are always on, so bit 0 of a pc is never used
  localparam int unsigned ADDR_OFFSET = 1;

  // two-bit saturating counter start value, weakly taken
  localparam logic [1:0] CTR_INIT = 2'b10;

  // register port widths
  localparam int unsigned CFG_ADDR_W = 4;
  localparam int unsigned CFG_DATA_W = 32;

  // register map
  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_CTRL = 4'h0;
  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MISP = 4'h4;

  // control word layout
  // bit 0 enables taken predictions
  localparam int unsigned CTRL_ENABLE_BIT = 0;
  // bit 1 requests a one-cycle direction table flush, reads back while pending
  localparam int unsigned CTRL_FLUSH_BIT = 1;

endpackage

// File: verilog/local_hist_bht.sv
module local_hist_bht #(
  parameter int unsigned NR_ENTRIES      = 256,
  parameter int unsigned HISTORY_LENGTH  = 3,
  parameter int unsigned INSTR_PER_FETCH = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         enable_i,
  input  logic [bpred_pkg::VLEN-1:0]   vpc_i,
  input  logic                         upd_valid_i,
  input  logic [bpred_pkg::VLEN-1:0]   upd_pc_i,
  input  logic                         upd_taken_i,
  output logic [INSTR_PER_FETCH-1:0]   pred_valid_o,
  output logic [INSTR_PER_FETCH-1:0]   pred_taken_o
);

  import bpred_pkg::*;

  // table is folded into rows holding one entry per fetch slot
  localparam int unsigned NR_ROWS = NR_ENTRIES / INSTR_PER_FETCH;
  localparam int unsigned ROW_W   = $clog2(NR_ROWS);
  // slot select bits sit between the offset and the row index
  localparam int unsigned SLOT_BITS = $clog2(INSTR_PER_FETCH);
  localparam int unsigned COL_W     = (INSTR_PER_FETCH > 1) ? SLOT_BITS : 1;
  localparam int unsigned ROW_LSB   = SLOT_BITS + ADDR_OFFSET;
  localparam int unsigned ROW_MSB   = ROW_W + ROW_LSB - 1;
  // one counter per local history pattern
  localparam int unsigned N_CTR = 2 ** HISTORY_LENGTH;

  localparam logic [N_CTR-1:0][1:0] CTR_ROW_INIT = {N_CTR{CTR_INIT}};

  logic [INSTR_PER_FETCH-1:0]  valid_q [NR_ROWS];
  logic [HISTORY_LENGTH-1:0]   hist_q  [NR_ROWS][INSTR_PER_FETCH];
  logic [N_CTR-1:0][1:0]       ctr_q   [NR_ROWS][INSTR_PER_FETCH];

  logic [ROW_W-1:0]            rd_row;
  logic [ROW_W-1:0]            upd_row;
  logic [COL_W-1:0]            upd_col;
  logic [HISTORY_LENGTH-1:0]   upd_hist;
  logic [HISTORY_LENGTH:0]     upd_hist_shift;
  logic [1:0]                  upd_ctr;
  logic [1:0]                  upd_ctr_next;

  assign rd_row  = vpc_i[ROW_MSB:ROW_LSB];
  assign upd_row = upd_pc_i[ROW_MSB:ROW_LSB];

  if (INSTR_PER_FETCH > 1) begin : gen_upd_col
    assign upd_col = upd_pc_i[ROW_LSB-1:ADDR_OFFSET];
  end else begin : gen_upd_col_single
    assign upd_col = '0;
  end

  // each slot reads the counter picked by its own history
  for (genvar i = 0; i < INSTR_PER_FETCH; i++) begin : gen_pred
    assign pred_valid_o[i] = valid_q[rd_row][i];
    assign pred_taken_o[i] = enable_i & ctr_q[rd_row][i][hist_q[rd_row][i]][1];
  end

  assign upd_hist = hist_q[upd_row][upd_col];
  assign upd_ctr  = ctr_q[upd_row][upd_col][upd_hist];
  // oldest outcome drops off the top
  assign upd_hist_shift = {upd_hist, upd_taken_i};

  // saturate at both ends, never wrap
  always_comb begin
    upd_ctr_next = upd_ctr;
    if (upd_taken_i && upd_ctr != 2'b11) begin
      upd_ctr_next = upd_ctr + 2'd1;
    end else if (!upd_taken_i && upd_ctr != 2'b00) begin
      upd_ctr_next = upd_ctr - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '{default: '0};
      hist_q  <= '{default: '0};
      ctr_q   <= '{default: CTR_ROW_INIT};
    end else if (flush_i) begin
      // flush wins over a same-cycle update
      valid_q <= '{default: '0};
      hist_q  <= '{default: '0};
      ctr_q   <= '{default: CTR_ROW_INIT};
    end else if (upd_valid_i) begin
      valid_q[upd_row][upd_col]           <= 1'b1;
      hist_q[upd_row][upd_col]            <= upd_hist_shift[HISTORY_LENGTH-1:0];
      ctr_q[upd_row][upd_col][upd_hist]   <= upd_ctr_next;
    end
  end

endmodule

// File: verilog/branch_target_buffer.sv
module branch_target_buffer #(
  parameter int unsigned BTB_ENTRIES = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [bpred_pkg::VLEN-1:0]   vpc_i,
  input  logic                         upd_valid_i,
  input  logic [bpred_pkg::VLEN-1:0]   upd_pc_i,
  input  logic                         upd_taken_i,
  input  logic [bpred_pkg::VLEN-1:0]   upd_target_i,
  output logic                         btb_hit_o,
  output logic [bpred_pkg::VLEN-1:0]   btb_target_o
);

  import bpred_pkg::*;

  // direct mapped, index right above the offset bit
  localparam int unsigned IDX_W   = $clog2(BTB_ENTRIES);
  localparam int unsigned IDX_LSB = ADDR_OFFSET;
  localparam int unsigned IDX_MSB = IDX_LSB + IDX_W - 1;
  // everything above the index is kept as tag
  localparam int unsigned TAG_LSB = IDX_MSB + 1;
  localparam int unsigned TAG_W   = VLEN - TAG_LSB;

  logic [BTB_ENTRIES-1:0]  valid_q;
  logic [TAG_W-1:0]        tag_q    [BTB_ENTRIES];
  logic [VLEN-1:0]         target_q [BTB_ENTRIES];

  logic [IDX_W-1:0]        rd_idx;
  logic [TAG_W-1:0]        rd_tag;
  logic [IDX_W-1:0]        wr_idx;
  logic [TAG_W-1:0]        wr_tag;
  logic                    wr_en;

  assign rd_idx = vpc_i[IDX_MSB:IDX_LSB];
  assign rd_tag = vpc_i[VLEN-1:TAG_LSB];

  assign wr_idx = upd_pc_i[IDX_MSB:IDX_LSB];
  assign wr_tag = upd_pc_i[VLEN-1:TAG_LSB];

  // only taken branches allocate, a not-taken report keeps the old target
  assign wr_en = upd_valid_i & upd_taken_i;

  // lookup
  assign btb_hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign btb_target_o = target_q[rd_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // tag and target storage, qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= upd_target_i;
    end
  end

endmodule

// File: verilog/bpred_cfg_regs.sv
module bpred_cfg_regs (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  input  logic                               cfg_we_i,
  input  logic [bpred_pkg::CFG_ADDR_W-1:0]   cfg_addr_i,
  input  logic [bpred_pkg::CFG_DATA_W-1:0]   cfg_wdata_i,
  input  logic                               upd_valid_i,
  input  logic                               upd_mispredict_i,
  output logic                               predict_en_o,
  output logic                               bht_flush_o,
  output logic [bpred_pkg::CFG_DATA_W-1:0]   cfg_rdata_o
);

  import bpred_pkg::*;

  logic                    enable_q;
  logic                    flush_pend_q;
  logic [CFG_DATA_W-1:0]   misp_cnt_q;
  logic                    ctrl_we;
  logic                    misp_we;

  assign ctrl_we = cfg_we_i && (cfg_addr_i == CFG_ADDR_CTRL);
  assign misp_we = cfg_we_i && (cfg_addr_i == CFG_ADDR_MISP);

  assign predict_en_o = enable_q;
  // external level and the one-cycle software request share one output
  assign bht_flush_o  = flush_i | flush_pend_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q     <= 1'b1;
      flush_pend_q <= 1'b0;
      misp_cnt_q   <= '0;
    end else begin
      // self clearing, only lives for the cycle after the write
      flush_pend_q <= ctrl_we & cfg_wdata_i[CTRL_FLUSH_BIT];
      if (ctrl_we) begin
        enable_q <= cfg_wdata_i[CTRL_ENABLE_BIT];
      end
      // any write to the counter clears it, data is ignored
      if (misp_we) begin
        misp_cnt_q <= '0;
      end else if (upd_valid_i && upd_mispredict_i && misp_cnt_q != '1) begin
        misp_cnt_q <= misp_cnt_q + 1'b1;
      end
    end
  end

  // read mux, unmapped addresses return zero
  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      CFG_ADDR_CTRL: begin
        cfg_rdata_o[CTRL_ENABLE_BIT] = enable_q;
        cfg_rdata_o[CTRL_FLUSH_BIT]  = flush_pend_q;
      end
      CFG_ADDR_MISP: cfg_rdata_o = misp_cnt_q;
      default:       cfg_rdata_o = '0;
    endcase
  end

endmodule

// File: verilog/bpred_top.sv
module bpred_top #(
  parameter int unsigned NR_ENTRIES      = 256,
  parameter int unsigned HISTORY_LENGTH  = 3,
  parameter int unsigned INSTR_PER_FETCH = 2,
  parameter int unsigned BTB_ENTRIES     = 16
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // fetch side
  input  logic [bpred_pkg::VLEN-1:0]         vpc_i,
  output logic [INSTR_PER_FETCH-1:0]         pred_valid_o,
  output logic [INSTR_PER_FETCH-1:0]         pred_taken_o,
  output logic                               btb_hit_o,
  output logic [bpred_pkg::VLEN-1:0]         btb_target_o,
  // resolved branch report
  input  logic                               upd_valid_i,
  input  logic [bpred_pkg::VLEN-1:0]         upd_pc_i,
  input  logic                               upd_taken_i,
  input  logic [bpred_pkg::VLEN-1:0]         upd_target_i,
  input  logic                               upd_mispredict_i,
  input  logic                               flush_i,
  // register port
  input  logic                               cfg_we_i,
  input  logic [bpred_pkg::CFG_ADDR_W-1:0]   cfg_addr_i,
  input  logic [bpred_pkg::CFG_DATA_W-1:0]   cfg_wdata_i,
  output logic [bpred_pkg::CFG_DATA_W-1:0]   cfg_rdata_o
);

  logic predict_en;
  logic bht_flush;

  bpred_cfg_regs i_cfg_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_addr_i       (cfg_addr_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .upd_valid_i      (upd_valid_i),
    .upd_mispredict_i (upd_mispredict_i),
    .predict_en_o     (predict_en),
    .bht_flush_o      (bht_flush),
    .cfg_rdata_o      (cfg_rdata_o)
  );

  // direction table, the only block that sees the flush
  local_hist_bht #(
    .NR_ENTRIES      (NR_ENTRIES),
    .HISTORY_LENGTH  (HISTORY_LENGTH),
    .INSTR_PER_FETCH (INSTR_PER_FETCH)
  ) i_bht (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (bht_flush),
    .enable_i     (predict_en),
    .vpc_i        (vpc_i),
    .upd_valid_i  (upd_valid_i),
    .upd_pc_i     (upd_pc_i),
    .upd_taken_i  (upd_taken_i),
    .pred_valid_o (pred_valid_o),
    .pred_taken_o (pred_taken_o)
  );

  branch_target_buffer #(
    .BTB_ENTRIES (BTB_ENTRIES)
  ) i_btb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .vpc_i        (vpc_i),
    .upd_valid_i  (upd_valid_i),
    .upd_pc_i     (upd_pc_i),
    .upd_taken_i  (upd_taken_i),
    .upd_target_i (upd_target_i),
    .btb_hit_o    (btb_hit_o),
    .btb_target_o (btb_target_o)
  );

endmodule

// File: tb/bpred_props.sv
module bpred_props #(
  parameter int unsigned INSTR_PER_FETCH = 2
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         upd_valid_i,
  input logic                         bht_flush_i,
  input logic [INSTR_PER_FETCH-1:0]   pred_valid_i,
  input logic                         btb_hit_i,
  input logic [bpred_pkg::VLEN-1:0]   btb_target_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // set by the first resolved branch after reset
  logic upd_seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      upd_seen_q <= 1'b0;
    end else if (upd_valid_i) begin
      upd_seen_q <= 1'b1;
    end
  end

  a_no_valid_before_update: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !upd_seen_q |-> pred_valid_i == '0)
    else $error("direction entry valid before any update");

  a_hit_target_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    btb_hit_i |-> !$isunknown(btb_target_i))
    else $error("target buffer hit with unknown target");

  a_flush_clears_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bht_flush_i |=> pred_valid_i == '0)
    else $error("direction entry still valid after flush");

endmodule

bind bpred_top bpred_props #(
  .INSTR_PER_FETCH (INSTR_PER_FETCH)
) i_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .upd_valid_i  (upd_valid_i),
  .bht_flush_i  (bht_flush),
  .pred_valid_i (pred_valid_o),
  .btb_hit_i    (btb_hit_o),
  .btb_target_i (btb_target_o)
);

// File: tb/bpred_tb.sv
module bpred_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import bpred_pkg::*;

  localparam int unsigned NR_ENTRIES      = 256;
  localparam int unsigned HISTORY_LENGTH  = 3;
  localparam int unsigned INSTR_PER_FETCH = 2;
  localparam int unsigned BTB_ENTRIES     = 16;
  localparam int unsigned CLK_PERIOD      = 40;
  localparam string       GOLDEN_FILE     = "tb/bpred_golden.txt";

  logic                         clk_i;
  logic                         rst_ni;
  logic [VLEN-1:0]              vpc_i;
  logic [INSTR_PER_FETCH-1:0]   pred_valid_o;
  logic [INSTR_PER_FETCH-1:0]   pred_taken_o;
  logic                         btb_hit_o;
  logic [VLEN-1:0]              btb_target_o;
  logic                         upd_valid_i;
  logic [VLEN-1:0]              upd_pc_i;
  logic                         upd_taken_i;
  logic [VLEN-1:0]              upd_target_i;
  logic                         upd_mispredict_i;
  logic                         flush_i;
  logic                         cfg_we_i;
  logic [CFG_ADDR_W-1:0]        cfg_addr_i;
  logic [CFG_DATA_W-1:0]        cfg_wdata_i;
  logic [CFG_DATA_W-1:0]        cfg_rdata_o;

  logic [31:0]                  rng_state = 32'ha900_e434;
  longint unsigned              wd_limit_ns = 0;

  bpred_top #(
    .NR_ENTRIES      (NR_ENTRIES),
    .HISTORY_LENGTH  (HISTORY_LENGTH),
    .INSTR_PER_FETCH (INSTR_PER_FETCH),
    .BTB_ENTRIES     (BTB_ENTRIES)
  ) DUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .vpc_i            (vpc_i),
    .pred_valid_o     (pred_valid_o),
    .pred_taken_o     (pred_taken_o),
    .btb_hit_o        (btb_hit_o),
    .btb_target_o     (btb_target_o),
    .upd_valid_i      (upd_valid_i),
    .upd_pc_i         (upd_pc_i),
    .upd_taken_i      (upd_taken_i),
    .upd_target_i     (upd_target_i),
    .upd_mispredict_i (upd_mispredict_i),
    .flush_i          (flush_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_addr_i       (cfg_addr_i),
    .cfg_wdata_i      (cfg_wdata_i),
    .cfg_rdata_o      (cfg_rdata_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // comment and blank lines carry no step
  function automatic bit is_step_line(input string line);
    return line.len() > 1 && line.getc(0) != "#";
  endfunction

  function automatic bit is_known_op(input string op);
    return op == "update" || op == "lookup" || op == "cfgwrite" ||
           op == "cfgread" || op == "flush";
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t ns: %s got %0h expected %0h", $time, what, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // strobes drop back to idle between steps
  task automatic idle_inputs();
    upd_valid_i      = 1'b0;
    upd_mispredict_i = 1'b0;
    flush_i          = 1'b0;
    cfg_we_i         = 1'b0;
  endtask

  task automatic open_golden(output int fd);
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the golden file %s", GOLDEN_FILE);
      $display("STATUS: FAIL");
      $fatal(1, "no stimulus");
    end
  endtask

  task automatic count_steps(output int unsigned steps);
    int    fd;
    string line;
    steps = 0;
    open_golden(fd);
    while ($fgets(line, fd) != 0) begin
      if (is_step_line(line)) begin
        steps++;
      end
    end
    $fclose(fd);
  endtask

  // one cycle per step, outputs checked just before the next rising edge
  task automatic run_step(input string op, input logic [31:0] f1, input logic [31:0] f2,
                          input logic [31:0] f3, input logic [31:0] f4,
                          input logic [31:0] f5, input int unsigned line_no);
    case (op)
      "update": begin
        upd_valid_i      = 1'b1;
        upd_pc_i         = f1;
        upd_taken_i      = f2[0];
        upd_target_i     = f3;
        upd_mispredict_i = f4[0];
      end
      "lookup": vpc_i = f1;
      "cfgwrite": begin
        cfg_we_i    = 1'b1;
        cfg_addr_i  = f1[CFG_ADDR_W-1:0];
        cfg_wdata_i = f2;
      end
      "cfgread": cfg_addr_i = f1[CFG_ADDR_W-1:0];
      default:   flush_i = 1'b1;
    endcase
    #(CLK_PERIOD / 2 - 1);
    if (op == "lookup") begin
      check_value(32'(pred_valid_o), f2, $sformatf("line %0d pred_valid_o", line_no));
      check_value(32'(pred_taken_o), f3, $sformatf("line %0d pred_taken_o", line_no));
      check_value(32'(btb_hit_o), f4, $sformatf("line %0d btb_hit_o", line_no));
      // target is only meaningful on a hit
      if (f4[0]) begin
        check_value(btb_target_o, f5, $sformatf("line %0d btb_target_o", line_no));
      end
    end else if (op == "cfgread") begin
      check_value(cfg_rdata_o, f2, $sformatf("line %0d cfg_rdata_o", line_no));
    end
    @(negedge clk_i);
    idle_inputs();
  endtask

  task automatic run_golden();
    int          fd;
    int          n;
    int unsigned line_no;
    string       line;
    string       op;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] f5;
    line_no = 0;
    open_golden(fd);
    while ($fgets(line, fd) != 0) begin
      line_no++;
      if (is_step_line(line)) begin
        n = $sscanf(line, "%s %h %h %h %h %h", op, f1, f2, f3, f4, f5);
        if (n != 6 || !is_known_op(op)) begin
          $display("golden file line %0d cannot be parsed: %s", line_no, line);
          $display("STATUS: FAIL");
          $fatal(1, "bad stimulus line");
        end else begin
          // idle gap before each step, results must not depend on it
          rng_state = lcg_next(rng_state);
          repeat (rng_state[31:30]) @(negedge clk_i);
          run_step(op, f1, f2, f3, f4, f5, line_no);
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin : watchdog
    wait (wd_limit_ns != 0);
    #(wd_limit_ns);
    $display("the simulation timed out after %0d ns", wd_limit_ns);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    int unsigned steps;
    rst_ni       = 1'b0;
    vpc_i        = '0;
    upd_pc_i     = '0;
    upd_taken_i  = 1'b0;
    upd_target_i = '0;
    cfg_addr_i   = '0;
    cfg_wdata_i  = '0;
    idle_inputs();
    count_steps(steps);
    // each step plus its worst gap, and reset time on top
    wd_limit_ns = longint'(steps) * 5 * CLK_PERIOD + 20 * CLK_PERIOD;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    run_golden();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: tb/bpred_golden.txt
# op       f1        f2     f3        f4   f5   (all fields hex)
# update   pc        taken  target    misp 0  | lookup  pc valid taken hit target
# cfgwrite addr      wdata  0         0    0  | cfgread addr rdata 0 0 0 | flush 0 0 0 0 0
lookup   00001040 0 3 0 0
lookup   8000000c 0 3 0 0
cfgread  4 00000000 0 0 0
cfgread  0 00000001 0 0 0
update   00001040 1 00002000 0 0
lookup   00001040 1 3 1 00002000
update   00001040 0 deadbeef 1 0
lookup   00001040 1 3 1 00002000
update   00001040 0 deadbeef 1 0
update   00001040 0 deadbeef 0 0
lookup   00001040 1 3 1 00002000
update   00001040 0 deadbeef 1 0
update   00001040 0 deadbeef 0 0
lookup   00001040 1 2 1 00002000
update   00001040 0 deadbeef 0 0
update   00001040 0 deadbeef 0 0
update   00001040 1 00002000 1 0
lookup   00001040 1 2 1 00002000
update   00001040 1 00002000 0 0
lookup   00001040 1 3 1 00002000
lookup   00001060 0 3 0 0
flush    0 0 0 0 0
lookup   00001040 0 3 1 00002000
update   00001040 1 00002000 0 0
lookup   00001040 1 3 1 00002000
cfgwrite 0 00000003 0 0 0
cfgread  8 00000000 0 0 0
lookup   00001040 0 3 1 00002000
cfgread  0 00000001 0 0 0
update   00001040 0 deadbeef 1 0
update   00001042 1 00003000 0 0
lookup   00001040 3 2 1 00002000
lookup   00001042 3 2 1 00003000
cfgwrite 0 00000000 0 0 0
cfgread  0 00000000 0 0 0
lookup   00001040 3 0 1 00002000
cfgwrite 0 00000001 0 0 0
lookup   00001040 3 2 1 00002000
cfgread  4 00000005 0 0 0
cfgwrite 4 0000ffff 0 0 0
cfgread  4 00000000 0 0 0
update   00001040 1 00002000 1 0
cfgread  4 00000001 0 0 0
lookup   00001040 3 3 1 00002000

// File: verilog.f
verilog/bpred_pkg.sv
verilog/local_hist_bht.sv
verilog/branch_target_buffer.sv
verilog/bpred_cfg_regs.sv
verilog/bpred_top.sv
tb/bpred_props.sv
tb/bpred_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module bpred_tb -Mdir "$BUILD_DIR" -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$("./$BUILD_DIR/Vbpred_tb")
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
else
  exit 1
fi
